//--- compile.f
+incdir+include
verilog/readout_pkg.sv
verilog/config_regs.sv
verilog/trigger_delay.sv
verilog/lane_sampler.sv
verilog/demod_rotator.sv
verilog/iq_integrator.sv
verilog/readout_top.sv
tests/tb_readout.sv

//--- include/readout_config.svh
`ifndef READOUT_CONFIG_SVH
`define READOUT_CONFIG_SVH

// datapath shape
`define READOUT_LANES   5       // lanes per clock
`define SAMPLE_W        16      // adc sample width
`define PHASE_W         6
`define PHASE_MOD       50      // one turn of phase
`define LUT_ROWS        10
`define TRIG_W          32      // sample times table entry
`define TRIG_AMP        16383   // sine/cosine table amplitude
`define ACC_W           48
`define CFG_W           32      // write data word

// register bank
`define ADDR_W          14
`define LEN_W           11
`define SKIP_W          6
`define DELAY_W         14

`define ADDR_LUT_BASE   10      // rows live at 10..19
`define ADDR_LENGTH     20
`define ADDR_SKIP       21
`define ADDR_DELAY      22

`define DEF_LENGTH      2000
`define DEF_SKIP        5
`define DEF_DELAY       5000

`endif

//--- run_sim.sh
#!/bin/sh
# build and run tb_readout with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f compile.f \
    --top-module tb_readout \
    -Mdir obj_dir \
    -o tb_readout
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_readout)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q -F "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tests/tb_readout.sv
`timescale 1ns/1ns
`include "readout_config.svh"

module tb_readout
    import readout_pkg::*;
();

    localparam real PI = 3.14159265358979323846;

    localparam int T2_DELAY  = 7;
    localparam int T2_LENGTH = 23;
    localparam int T3_DELAY  = 12;
    localparam int T3_LENGTH = 17;
    localparam int T4_DELAY  = 9;
    localparam int T4_LENGTH = 20;
    localparam int T5_DELAY  = 40;
    localparam int T5_LENGTH = 30;

    // test 4 runs twice and test 5 idles one more run for stray strobes
    localparam int WATCHDOG_CYCLES = (`DEF_DELAY + `DEF_LENGTH + 20)
                                   + (T2_DELAY + T2_LENGTH + 20)
                                   + (T3_DELAY + T3_LENGTH + 20)
                                   + 2 * (T4_DELAY + T4_LENGTH + 20)
                                   + 2 * (T5_DELAY + T5_LENGTH + 20)
                                   + 600;   // writes and gaps

    logic                clk100;
    logic                reset;
    logic                i_cfg_wr;
    logic [`ADDR_W-1:0]  i_cfg_addr;
    cfg_word_u           i_cfg_data;
    logic                i_trigger;
    lane_samples_t       i_adc_i;
    lane_samples_t       i_adc_q;
    logic                o_iq_valid;
    acc_t                o_i_total;
    acc_t                o_q_total;

    // shadow of the register bank
    phase_table_t         sh_table;
    logic [`LEN_W-1:0]    sh_length;
    logic [`SKIP_W-1:0]   sh_skip;
    logic [`DELAY_W-1:0]  sh_delay;

    lane_samples_t cap_i [$];   // one entry per group of the last run
    lane_samples_t cap_q [$];

    int     valid_count = 0;
    int     checks = 0;
    int     errors = 0;
    int     edge_count = 0;     // rising edges so far
    int     trig_edge = 0;      // edge that took the accepted trigger
    integer seed = 52;

    readout_top readout_top_inst (
        .clk100     (clk100),
        .reset      (reset),
        .i_cfg_wr   (i_cfg_wr),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .i_trigger  (i_trigger),
        .i_adc_i    (i_adc_i),
        .i_adc_q    (i_adc_q),
        .o_iq_valid (o_iq_valid),
        .o_i_total  (o_i_total),
        .o_q_total  (o_q_total)
    );

    initial begin : clock_gen
        clk100 = 1'b0;
        forever #4 clk100 = ~clk100;
    end

    initial begin : adc_stimulus
        forever begin
            @(negedge clk100);
            for (int l = 0; l < `READOUT_LANES; l++) begin
                i_adc_i[l] = sample_t'($random(seed));
                i_adc_q[l] = sample_t'($random(seed));
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk100);
        $display("timeout: o_iq_valid never came within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input longint got, input longint exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s mismatch, got %0d, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    function automatic longint round_real(input real x);
        if (x >= 0.0) begin
            return longint'($rtoi(x + 0.5));
        end
        return -longint'($rtoi(-x + 0.5));
    endfunction

    // expected totals from the captured groups and the shadow settings
    function automatic void ref_totals(output longint tot_i, output longint tot_q);
        int     skip_eff;
        int     p;
        real    ang;
        longint cos_v, sin_v, vi, vq;
        skip_eff = (sh_skip == 0) ? 1 : int'(sh_skip);
        tot_i = 0;
        tot_q = 0;
        for (int g = 0; g < cap_i.size(); g++) begin
            for (int l = 0; l < `READOUT_LANES; l++) begin
                if (((`READOUT_LANES * g + l) % skip_eff) == 0) begin
                    p     = int'(sh_table[g % `LUT_ROWS][l]) % `PHASE_MOD;
                    ang   = 2.0 * PI * real'(p) / real'(`PHASE_MOD);
                    cos_v = round_real(real'(`TRIG_AMP) * $cos(ang));
                    sin_v = round_real(real'(`TRIG_AMP) * $sin(ang));
                    vi    = cap_i[g][l];
                    vq    = cap_q[g][l];
                    tot_i = tot_i + vi * cos_v + vq * sin_v;
                    tot_q = tot_q + vq * cos_v - vi * sin_v;
                end
            end
        end
    endfunction

    // group 0 is the adc word seen delay+1 edges after the trigger edge
    initial begin : capture_adc
        int countdown;
        bit grabbing;
        countdown = 0;
        grabbing  = 1'b0;
        forever begin
            @(posedge clk100);
            edge_count++;
            if (countdown > 0) begin
                countdown = countdown - 1;
                grabbing  = (countdown == 0);
            end else if (!grabbing && !reset && i_trigger) begin
                countdown = (sh_delay == 0) ? 2 : int'(sh_delay) + 1;
                trig_edge = edge_count;
                cap_i.delete();
                cap_q.delete();
            end
            if (grabbing) begin
                cap_i.push_back(i_adc_i);
                cap_q.push_back(i_adc_q);
                if (cap_i.size() >= int'(sh_length)) grabbing = 1'b0;
            end
        end
    end

    initial begin : compare_results
        longint exp_i;
        longint exp_q;
        int     delay_eff;
        forever begin
            @(negedge clk100);
            if (o_iq_valid === 1'b1) begin
                valid_count++;
                ref_totals(exp_i, exp_q);
                delay_eff = (sh_delay == 0) ? 1 : int'(sh_delay);
                // strobe cycle ends on the next edge
                check_value("result latency", edge_count + 1 - trig_edge,
                            delay_eff + int'(sh_length) + 4);
                check_value("I total", o_i_total, exp_i);
                check_value("Q total", o_q_total, exp_q);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////////////

    task automatic write_reg(input int addr, input logic [31:0] data);
        @(negedge clk100);
        i_cfg_wr          = 1'b1;
        i_cfg_addr        = `ADDR_W'(addr);
        i_cfg_data.scalar = data;
        @(negedge clk100);
        i_cfg_wr = 1'b0;
        if (addr >= `ADDR_LUT_BASE && addr < `ADDR_LUT_BASE + `LUT_ROWS) begin
            sh_table[addr - `ADDR_LUT_BASE] = data[`READOUT_LANES*`PHASE_W-1:0];
        end else if (addr == `ADDR_LENGTH) begin
            sh_length = data[`LEN_W-1:0];
        end else if (addr == `ADDR_SKIP) begin
            sh_skip = data[`SKIP_W-1:0];
        end else if (addr == `ADDR_DELAY) begin
            sh_delay = data[`DELAY_W-1:0];
        end
    endtask

    task automatic write_row(input int r);
        phase_row_t row;
        for (int l = 0; l < `READOUT_LANES; l++) begin
            row[l] = phase_t'((7 * r + 13 * l + 3) % 64);   // some codes past 49
        end
        write_reg(`ADDR_LUT_BASE + r, 32'(row));
    endtask

    task automatic set_params(input int length, input int skip, input int delay);
        write_reg(`ADDR_LENGTH, 32'(length));
        write_reg(`ADDR_SKIP, 32'(skip));
        write_reg(`ADDR_DELAY, 32'(delay));
    endtask

    task automatic fire_trigger();
        @(negedge clk100);
        i_trigger = 1'b1;
        @(negedge clk100);
        i_trigger = 1'b0;
    endtask

    task automatic wait_result(input int n);
        wait (valid_count >= n);
        repeat (8) @(negedge clk100);
        check_value("result strobes", valid_count, n);
    endtask

    initial begin : main_sequence
        reset      = 1'b1;
        i_cfg_wr   = 1'b0;
        i_cfg_addr = '0;
        i_cfg_data = '0;
        i_trigger  = 1'b0;
        i_adc_i    = '0;
        i_adc_q    = '0;
        sh_length  = `DEF_LENGTH;
        sh_skip    = `DEF_SKIP;
        sh_delay   = `DEF_DELAY;
        for (int r = 0; r < `LUT_ROWS; r++) begin
            for (int l = 0; l < `READOUT_LANES; l++) begin
                sh_table[r][l] = (r % 2 == 0) ? phase_t'(5 * l) : phase_t'(25 + 5 * l);
            end
        end
        repeat (4) @(posedge clk100);
        @(negedge clk100);
        reset = 1'b0;

        // defaults with no strobe allowed before the run ends
        repeat (10) @(negedge clk100);
        check_value("strobes before first trigger", valid_count, 0);
        fire_trigger();
        wait_result(1);

        // new table with every lane sampled
        for (int r = 0; r < `LUT_ROWS; r++) begin
            write_row(r);
        end
        set_params(T2_LENGTH, 1, T2_DELAY);
        fire_trigger();
        wait_result(2);

        set_params(T3_LENGTH, 3, T3_DELAY);
        fire_trigger();
        wait_result(3);

        // skips wider than a group
        set_params(T4_LENGTH, 7, T4_DELAY);
        fire_trigger();
        wait_result(4);
        set_params(T4_LENGTH, 12, T4_DELAY);
        fire_trigger();
        wait_result(5);

        // dropped addresses and a retrigger inside the delay
        set_params(T5_LENGTH, 4, T5_DELAY);
        write_reg(0, 32'hdead_beef);
        for (int a = 30; a <= 40; a++) begin
            write_reg(a, 32'h5a5a_0000 | 32'(a));
        end
        fire_trigger();
        repeat (10) @(negedge clk100);
        fire_trigger();
        wait_result(6);
        repeat (T5_DELAY + T5_LENGTH + 20) @(negedge clk100);
        check_value("strobes after double trigger", valid_count, 6);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog/config_regs.sv
`timescale 1ns/1ns
`include "readout_config.svh"

module config_regs
    import readout_pkg::*;
(
    input  logic                  clk100,
    input  logic                  reset,
    input  logic                  i_cfg_wr,
    input  logic [`ADDR_W-1:0]    i_cfg_addr,
    input  cfg_word_u             i_cfg_data,
    output phase_table_t          o_phase_table,
    output logic [`LEN_W-1:0]     o_sample_length,
    output logic [`SKIP_W-1:0]    o_sample_skip,
    output logic [`DELAY_W-1:0]   o_delay
);

    localparam int ROWS  = `LUT_ROWS;
    localparam int LANES = `READOUT_LANES;

    localparam logic [`ADDR_W-1:0] A_LUT_BASE = `ADDR_LUT_BASE;
    localparam logic [`ADDR_W-1:0] A_LENGTH   = `ADDR_LENGTH;
    localparam logic [`ADDR_W-1:0] A_SKIP     = `ADDR_SKIP;
    localparam logic [`ADDR_W-1:0] A_DELAY    = `ADDR_DELAY;

    //////////////////////////////////////////////////////////////////////
    // phase table
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100) begin
        if (reset) begin
            // even rows 0,5,..,20 and odd rows 25,30,..,45
            for (int r = 0; r < ROWS; r++) begin
                for (int l = 0; l < LANES; l++) begin
                    o_phase_table[r][l] <= phase_t'(5 * (l + LANES * (r % 2)));
                end
            end
        end else if (i_cfg_wr) begin
            for (int r = 0; r < ROWS; r++) begin
                if (i_cfg_addr == A_LUT_BASE + `ADDR_W'(r)) begin
                    o_phase_table[r] <= i_cfg_data.lut.row;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // scalar settings
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100) begin
        if (reset) begin
            o_sample_length <= `LEN_W'(`DEF_LENGTH);
            o_sample_skip   <= `SKIP_W'(`DEF_SKIP);
            o_delay         <= `DELAY_W'(`DEF_DELAY);
        end else if (i_cfg_wr) begin
            case (i_cfg_addr)
                A_LENGTH: o_sample_length <= i_cfg_data.scalar[`LEN_W-1:0];
                A_SKIP:   o_sample_skip   <= i_cfg_data.scalar[`SKIP_W-1:0];
                A_DELAY:  o_delay         <= i_cfg_data.scalar[`DELAY_W-1:0];
                default: ; // unmapped, dropped
            endcase
        end
    end

endmodule

//--- verilog/demod_rotator.sv
`timescale 1ns/1ns
`include "readout_config.svh"

module demod_rotator
    import readout_pkg::*;
(
    input  logic           clk100,
    input  logic           reset,
    input  lane_samples_t  i_adc_i,
    input  lane_samples_t  i_adc_q,
    input  lane_mask_t     i_mask,
    input  phase_row_t     i_phases,
    input  logic           i_group_valid,
    input  logic           i_last,
    output lane_rot_t      o_rot_i,
    output lane_rot_t      o_rot_q,
    output logic           o_group_valid,
    output logic           o_last
);

    localparam int  LANES = `READOUT_LANES;
    localparam int  TAB_N = 2 ** `PHASE_W;
    localparam real PI    = 3.14159265358979323846;

    typedef logic signed [`SAMPLE_W-1:0] trig_t;
    typedef logic signed [`TRIG_W-1:0]   prod_t;

    trig_t cos_tab [TAB_N];
    trig_t sin_tab [TAB_N];

    // table over all 6-bit codes, phase taken mod 50
    for (genvar g = 0; g < TAB_N; g++) begin : g_tab
        localparam real ANG = 2.0 * PI * real'(g % `PHASE_MOD) / real'(`PHASE_MOD);
        assign cos_tab[g] = trig_t'(int'(real'(`TRIG_AMP) * $cos(ANG)));
        assign sin_tab[g] = trig_t'(int'(real'(`TRIG_AMP) * $sin(ANG)));
    end

    //////////////////////////////////////////////////////////////////////
    // stage 1: table lookup
    //////////////////////////////////////////////////////////////////////

    lane_samples_t  i_s1, q_s1;
    lane_mask_t     mask_s1;
    trig_t          cos_s1 [LANES];
    trig_t          sin_s1 [LANES];
    logic           valid_s1, last_s1;

    always_ff @(posedge clk100) begin
        i_s1    <= i_adc_i;
        q_s1    <= i_adc_q;
        mask_s1 <= i_mask;
        for (int l = 0; l < LANES; l++) begin
            cos_s1[l] <= cos_tab[i_phases[l]];
            sin_s1[l] <= sin_tab[i_phases[l]];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: complex rotation
    //////////////////////////////////////////////////////////////////////

    prod_t p_ic [LANES];
    prod_t p_qs [LANES];
    prod_t p_qc [LANES];
    prod_t p_is [LANES];

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            p_ic[l] = $signed(i_s1[l]) * $signed(cos_s1[l]);
            p_qs[l] = $signed(q_s1[l]) * $signed(sin_s1[l]);
            p_qc[l] = $signed(q_s1[l]) * $signed(cos_s1[l]);
            p_is[l] = $signed(i_s1[l]) * $signed(sin_s1[l]);
        end
    end

    always_ff @(posedge clk100) begin
        for (int l = 0; l < LANES; l++) begin
            o_rot_i[l] <= mask_s1[l] ? rot_t'(p_ic[l]) + rot_t'(p_qs[l]) : '0;
            o_rot_q[l] <= mask_s1[l] ? rot_t'(p_qc[l]) - rot_t'(p_is[l]) : '0;
        end
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            valid_s1      <= 1'b0;
            last_s1       <= 1'b0;
            o_group_valid <= 1'b0;
            o_last        <= 1'b0;
        end else begin
            valid_s1      <= i_group_valid;
            last_s1       <= i_last;
            o_group_valid <= valid_s1;
            o_last        <= last_s1;
        end
    end

endmodule

//--- verilog/iq_integrator.sv
`timescale 1ns/1ns
`include "readout_config.svh"

module iq_integrator
    import readout_pkg::*;
(
    input  logic       clk100,
    input  logic       reset,
    input  lane_rot_t  i_rot_i,
    input  lane_rot_t  i_rot_q,
    input  logic       i_group_valid,
    input  logic       i_last,
    output logic       o_iq_valid,
    output acc_t       o_i_total,
    output acc_t       o_q_total
);

    localparam int LANES = `READOUT_LANES;

    logic  in_run;          // a run has started and not yet ended
    acc_t  acc_i, acc_q;
    acc_t  sum_i, sum_q;    // this group across lanes
    acc_t  base_i, base_q;

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int l = 0; l < LANES; l++) begin
            sum_i = sum_i + acc_t'($signed(i_rot_i[l]));
            sum_q = sum_q + acc_t'($signed(i_rot_q[l]));
        end
    end

    // first group of a run starts from zero
    assign base_i = in_run ? acc_i : '0;
    assign base_q = in_run ? acc_q : '0;

    always_ff @(posedge clk100) begin
        if (reset) begin
            in_run     <= 1'b0;
            acc_i      <= '0;
            acc_q      <= '0;
            o_iq_valid <= 1'b0;
            o_i_total  <= '0;
            o_q_total  <= '0;
        end else begin
            o_iq_valid <= 1'b0;
            if (i_group_valid) begin
                acc_i  <= base_i + sum_i;
                acc_q  <= base_q + sum_q;
                in_run <= ~i_last;
                if (i_last) begin
                    o_i_total  <= base_i + sum_i;   // held until the next run ends
                    o_q_total  <= base_q + sum_q;
                    o_iq_valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/lane_sampler.sv
`timescale 1ns/1ns
`include "readout_config.svh"

module lane_sampler
    import readout_pkg::*;
(
    input  logic                  clk100,
    input  logic                  reset,
    input  logic                  i_start,
    input  lane_samples_t         i_adc_i,
    input  lane_samples_t         i_adc_q,
    input  phase_table_t          i_phase_table,
    input  logic [`LEN_W-1:0]     i_sample_length,
    input  logic [`SKIP_W-1:0]    i_sample_skip,
    output lane_samples_t         o_adc_i,
    output lane_samples_t         o_adc_q,
    output lane_mask_t            o_mask,
    output phase_row_t            o_phases,
    output logic                  o_group_valid,
    output logic                  o_last
);

    localparam int LANES = `READOUT_LANES;
    localparam int ROW_W = $clog2(`LUT_ROWS);

    logic                  sampling;
    logic [`LEN_W-1:0]     group_cnt;
    logic [ROW_W-1:0]      row;
    logic [`SKIP_W-1:0]    offset;      // next sampled index, relative to lane 0

    logic                  take;
    logic [`LEN_W-1:0]     cur_cnt;
    logic [ROW_W-1:0]      cur_row;
    logic [`SKIP_W-1:0]    cur_off;
    logic [`SKIP_W-1:0]    skip_eff;
    logic                  last_group;
    lane_mask_t            mask_next;
    logic [`SKIP_W-1:0]    next_off;

    // start while sampling falls through, group 0 is the start cycle itself
    assign take     = sampling | i_start;
    assign cur_cnt  = sampling ? group_cnt : '0;
    assign cur_row  = sampling ? row : '0;
    assign cur_off  = sampling ? offset : '0;
    assign skip_eff = (i_sample_skip == '0) ? `SKIP_W'(1) : i_sample_skip;

    assign last_group = ({1'b0, cur_cnt} + 1'b1) >= {1'b0, i_sample_length};

    //////////////////////////////////////////////////////////////////////
    // walk the sampled indices through the group, no division needed
    //////////////////////////////////////////////////////////////////////

    always_comb begin : mask_scan
        logic [`SKIP_W+1:0] pos;
        pos = {2'b00, cur_off};
        for (int l = 0; l < LANES; l++) begin
            mask_next[l] = (pos == l);
            if (pos == l) begin
                pos = pos + skip_eff;
            end
        end
        next_off = `SKIP_W'(pos - LANES);   // pos is past lane 4 here
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            sampling      <= 1'b0;
            group_cnt     <= '0;
            row           <= '0;
            offset        <= '0;
            o_group_valid <= 1'b0;
            o_last        <= 1'b0;
        end else begin
            o_group_valid <= take;
            o_last        <= take & last_group;
            if (take) begin
                sampling  <= ~last_group;
                group_cnt <= cur_cnt + 1'b1;
                row       <= (cur_row == ROW_W'(`LUT_ROWS - 1)) ? '0 : cur_row + 1'b1;
                offset    <= next_off;
            end
        end
    end

    // data lines up with its mask and phase row
    always_ff @(posedge clk100) begin
        o_adc_i  <= i_adc_i;
        o_adc_q  <= i_adc_q;
        o_mask   <= take ? mask_next : '0;
        o_phases <= i_phase_table[cur_row];
    end

endmodule

//--- verilog/readout_pkg.sv
`include "readout_config.svh"

package readout_pkg;

    // adc side
    typedef logic signed [`SAMPLE_W-1:0] sample_t;
    typedef sample_t [`READOUT_LANES-1:0] lane_samples_t;

    // phase table
    typedef logic [`PHASE_W-1:0] phase_t;
    typedef phase_t [`READOUT_LANES-1:0] phase_row_t;   // one row, lane 0 in the low bits
    typedef phase_row_t [`LUT_ROWS-1:0] phase_table_t;

    typedef logic [`READOUT_LANES-1:0] lane_mask_t;     // high = lane sampled

    // rotated lane values carry one bit of growth over a single product
    typedef logic signed [`TRIG_W:0] rot_t;
    typedef rot_t [`READOUT_LANES-1:0] lane_rot_t;

    typedef logic signed [`ACC_W-1:0] acc_t;

    //////////////////////////////////////////////////////////////////////
    // write data word, read either as a table row or as a plain number
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`CFG_W-`READOUT_LANES*`PHASE_W-1:0] pad;
        phase_row_t                              row;
    } cfg_row_t;

    typedef union packed {
        cfg_row_t           lut;      // addresses 10..19
        logic [`CFG_W-1:0]  scalar;   // length, skip, delay
    } cfg_word_u;

endpackage

//--- verilog/readout_top.sv
`timescale 1ns/1ns
`include "readout_config.svh"

module readout_top
    import readout_pkg::*;
(
    input  logic                clk100,
    input  logic                reset,
    input  logic                i_cfg_wr,
    input  logic [`ADDR_W-1:0]  i_cfg_addr,
    input  cfg_word_u           i_cfg_data,
    input  logic                i_trigger,
    input  lane_samples_t       i_adc_i,
    input  lane_samples_t       i_adc_q,
    output logic                o_iq_valid,
    output acc_t                o_i_total,
    output acc_t                o_q_total
);

    // settings
    phase_table_t          phase_table;
    logic [`LEN_W-1:0]     sample_length;
    logic [`SKIP_W-1:0]    sample_skip;
    logic [`DELAY_W-1:0]   delay;

    logic                  start;

    // sampler to rotator
    lane_samples_t         smp_i, smp_q;
    lane_mask_t            smp_mask;
    phase_row_t            smp_phases;
    logic                  smp_valid, smp_last;

    // rotator to integrator
    lane_rot_t             rot_i, rot_q;
    logic                  rot_valid, rot_last;

    config_regs config_regs_inst (
        .clk100          (clk100),
        .reset           (reset),
        .i_cfg_wr        (i_cfg_wr),
        .i_cfg_addr      (i_cfg_addr),
        .i_cfg_data      (i_cfg_data),
        .o_phase_table   (phase_table),
        .o_sample_length (sample_length),
        .o_sample_skip   (sample_skip),
        .o_delay         (delay)
    );

    trigger_delay trigger_delay_inst (
        .clk100    (clk100),
        .reset     (reset),
        .i_trigger (i_trigger),
        .i_delay   (delay),
        .o_start   (start)
    );

    lane_sampler lane_sampler_inst (
        .clk100          (clk100),
        .reset           (reset),
        .i_start         (start),
        .i_adc_i         (i_adc_i),
        .i_adc_q         (i_adc_q),
        .i_phase_table   (phase_table),
        .i_sample_length (sample_length),
        .i_sample_skip   (sample_skip),
        .o_adc_i         (smp_i),
        .o_adc_q         (smp_q),
        .o_mask          (smp_mask),
        .o_phases        (smp_phases),
        .o_group_valid   (smp_valid),
        .o_last          (smp_last)
    );

    demod_rotator demod_rotator_inst (
        .clk100        (clk100),
        .reset         (reset),
        .i_adc_i       (smp_i),
        .i_adc_q       (smp_q),
        .i_mask        (smp_mask),
        .i_phases      (smp_phases),
        .i_group_valid (smp_valid),
        .i_last        (smp_last),
        .o_rot_i       (rot_i),
        .o_rot_q       (rot_q),
        .o_group_valid (rot_valid),
        .o_last        (rot_last)
    );

    iq_integrator iq_integrator_inst (
        .clk100        (clk100),
        .reset         (reset),
        .i_rot_i       (rot_i),
        .i_rot_q       (rot_q),
        .i_group_valid (rot_valid),
        .i_last        (rot_last),
        .o_iq_valid    (o_iq_valid),
        .o_i_total     (o_i_total),
        .o_q_total     (o_q_total)
    );

endmodule

//--- verilog/trigger_delay.sv
`timescale 1ns/1ns
`include "readout_config.svh"

module trigger_delay (
    input  logic                  clk100,
    input  logic                  reset,
    input  logic                  i_trigger,
    input  logic [`DELAY_W-1:0]   i_delay,
    output logic                  o_start
);

    typedef enum logic {
        ST_IDLE,
        ST_COUNT
    } state_t;

    state_t               state;
    logic [`DELAY_W-1:0]  count;
    logic [`DELAY_W-1:0]  delay_eff;

    // zero delay runs like one
    assign delay_eff = (i_delay == '0) ? `DELAY_W'(1) : i_delay;

    always_ff @(posedge clk100) begin
        if (reset) begin
            state   <= ST_IDLE;
            count   <= '0;
            o_start <= 1'b0;
        end else begin
            o_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_trigger) begin
                        state <= ST_COUNT;
                        count <= `DELAY_W'(1);
                    end
                end
                ST_COUNT: begin        // triggers ignored here
                    if (count == delay_eff) begin
                        o_start <= 1'b1;   // delay+1 after the trigger cycle
                        state   <= ST_IDLE;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule
